/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module tb_mem_subsys \
		-Mdir obj_dir -o tb_mem_subsys
	./obj_dir/tb_mem_subsys > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
mem_pkg.sv
lsu.sv
boot_loader.sv
bus_arbiter.sv
data_ram.sv
mem_subsys.sv
tb_mem_subsys.sv

/* boot_loader.sv */
`timescale 1ns/100ps

module boot_loader (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic [mem_pkg::STRB_W-1:0]      bl_strobe_i,
    input  logic [mem_pkg::BL_ADDR_W-1:0]   bl_addr_i,
    input  logic [mem_pkg::DATA_W-1:0]      bl_data_i,
    output logic                            bl_ready_o,
    output logic                            bl_hold_o,
    output logic [31:0]                     b_addr_o,
    output logic [mem_pkg::DATA_W-1:0]      b_data_o,
    output logic [mem_pkg::STRB_W-1:0]      b_strb_o,
    output logic                            b_write_o,
    input  logic                            b_ack_i
);
    import mem_pkg::*;

    localparam int DEPTH = 2;

    logic [BL_ADDR_W-1:0]   addr_q [DEPTH];
    logic [DATA_W-1:0]      data_q [DEPTH];
    logic [STRB_W-1:0]      strb_q [DEPTH];
    logic                   wr_ptr_q;
    logic                   rd_ptr_q;
    logic [1:0]             count_q;
    logic                   push;
    logic                   pop;

    assign push       = (|bl_strobe_i) & bl_ready_o;
    assign pop        = b_write_o & b_ack_i;
    assign bl_ready_o = (count_q != 2'(DEPTH));
    assign bl_hold_o  = (count_q != 2'd0);

    // head entry goes out as a byte-addressed write
    assign b_write_o = bl_hold_o;
    assign b_addr_o  = {{(32 - BL_ADDR_W - 2){1'b0}}, addr_q[rd_ptr_q], 2'b00};
    assign b_data_o  = data_q[rd_ptr_q];
    assign b_strb_o  = strb_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            addr_q[wr_ptr_q] <= bl_addr_i;
            data_q[wr_ptr_q] <= bl_data_i;
            strb_q[wr_ptr_q] <= bl_strobe_i;
        end
    end

    a_no_offer_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !bl_ready_o |-> (bl_strobe_i == '0));

endmodule

/* bus_arbiter.sv */
`timescale 1ns/100ps

module bus_arbiter (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic [31:0]                 m0_addr_i,
    input  logic [mem_pkg::DATA_W-1:0]  m0_data_i,
    input  logic [mem_pkg::STRB_W-1:0]  m0_strb_i,
    input  logic                        m0_read_i,
    input  logic                        m0_write_i,
    output logic                        m0_ack_o,
    output logic [mem_pkg::DATA_W-1:0]  m0_data_o,
    input  logic [31:0]                 m1_addr_i,
    input  logic [mem_pkg::DATA_W-1:0]  m1_data_i,
    input  logic [mem_pkg::STRB_W-1:0]  m1_strb_i,
    input  logic                        m1_read_i,
    input  logic                        m1_write_i,
    output logic                        m1_ack_o,
    output logic [mem_pkg::DATA_W-1:0]  m1_data_o,
    output logic [31:0]                 s_addr_o,
    output logic [mem_pkg::DATA_W-1:0]  s_data_o,
    output logic [mem_pkg::STRB_W-1:0]  s_strb_o,
    output logic                        s_read_o,
    output logic                        s_write_o,
    input  logic                        s_ack_i,
    input  logic [mem_pkg::DATA_W-1:0]  s_data_i
);
    logic req0;
    logic req1;
    logic busy_q;
    logic gnt_q;
    logic last_q;
    logic pick;
    logic sel;

    assign req0 = m0_read_i | m0_write_i;
    assign req1 = m1_read_i | m1_write_i;

    // on a tie the master that lost last time wins
    assign pick = (req0 & req1) ? ~last_q : req1;
    assign sel  = busy_q ? gnt_q : pick;

    assign s_addr_o  = sel ? m1_addr_i  : m0_addr_i;
    assign s_data_o  = sel ? m1_data_i  : m0_data_i;
    assign s_strb_o  = sel ? m1_strb_i  : m0_strb_i;
    assign s_read_o  = sel ? m1_read_i  : m0_read_i;
    assign s_write_o = sel ? m1_write_i : m0_write_i;

    assign m0_ack_o  = s_ack_i & busy_q & ~gnt_q;
    assign m1_ack_o  = s_ack_i & busy_q & gnt_q;
    assign m0_data_o = (busy_q & ~gnt_q) ? s_data_i : '0;
    assign m1_data_o = (busy_q & gnt_q) ? s_data_i : '0;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
            gnt_q  <= 1'b0;
            last_q <= 1'b1;
        end else if (!busy_q) begin
            if (req0 | req1) begin
                busy_q <= 1'b1;
                gnt_q  <= pick;
                last_q <= pick;
            end
        end else if (s_ack_i) begin
            busy_q <= 1'b0;
        end
    end

    // the granted master keeps its request up until the ack
    a_grant_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        busy_q |-> (gnt_q ? req1 : req0));

    // slave answers only a granted request
    a_ack_granted: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        s_ack_i |-> busy_q);

endmodule

/* data_ram.sv */
`timescale 1ns/100ps

module data_ram #(
    parameter int MEM_WORDS = 16384
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic [31:0]                 addr_i,
    input  logic [mem_pkg::DATA_W-1:0]  data_i,
    input  logic [mem_pkg::STRB_W-1:0]  strb_i,
    input  logic                        read_i,
    input  logic                        write_i,
    output logic                        ack_o,
    output logic [mem_pkg::DATA_W-1:0]  data_o
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [DATA_W-1:0]  mem_q [MEM_WORDS];
    logic [IDX_W-1:0]   idx;
    logic               serve;

    // word index from the low byte-address bits
    assign idx = addr_i[IDX_W+1:2];

    // a request still held in its ack cycle is not served again
    assign serve = (read_i | write_i) & ~ack_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= serve;
        end
    end

    always_ff @(posedge clk_i) begin
        if (serve && write_i) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (strb_i[i]) begin
                    mem_q[idx][8*i +: 8] <= data_i[8*i +: 8];
                end
            end
        end
        if (serve && read_i) begin
            data_o <= mem_q[idx];
        end
    end

    // masters keep the request steady into the ack cycle
    a_req_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        serve |=> (read_i | write_i) && $stable(addr_i));

endmodule

/* lsu.sv */
`timescale 1ns/100ps

module lsu (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        mem_read_i,
    input  logic                        mem_write_i,
    input  logic [31:0]                 addr_i,
    input  logic [mem_pkg::DATA_W-1:0]  wdata_i,
    input  mem_pkg::mem_mask_t          mask_i,
    output logic                        stall_o,
    output logic                        done_o,
    output logic [mem_pkg::DATA_W-1:0]  rdata_o,
    output logic [31:0]                 b_addr_o,
    output logic [mem_pkg::DATA_W-1:0]  b_data_o,
    output logic [mem_pkg::STRB_W-1:0]  b_strb_o,
    output logic                        b_read_o,
    output logic                        b_write_o,
    input  logic                        b_ack_i,
    input  logic [mem_pkg::DATA_W-1:0]  b_data_i
);
    import mem_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_BUS  = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;

    logic [1:0]         state_q;
    logic               req;
    logic               accept;
    mem_mask_t          mask_q;
    logic [1:0]         bank_q;
    mem_word_u          st_word;
    logic [STRB_W-1:0]  st_strb;
    mem_word_u          ld_word;
    logic [DATA_W-1:0]  ld_data;

    assign req     = mem_read_i | mem_write_i;
    assign accept  = req & (state_q != ST_BUS);
    assign stall_o = (state_q == ST_BUS);
    assign done_o  = (state_q == ST_DONE);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= ST_IDLE;
            b_read_o  <= 1'b0;
            b_write_o <= 1'b0;
        end else begin
            case (state_q)
                ST_BUS: begin
                    if (b_ack_i) begin
                        state_q   <= ST_DONE;
                        b_read_o  <= 1'b0;
                        b_write_o <= 1'b0;
                    end
                end
                // idle and done both take a new request
                default: begin
                    if (req) begin
                        state_q   <= ST_BUS;
                        b_read_o  <= mem_read_i;
                        b_write_o <= mem_write_i;
                    end else begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            b_addr_o <= addr_i;
            b_data_o <= st_word.word;
            b_strb_o <= st_strb;
            mask_q   <= mask_i;
            bank_q   <= addr_i[1:0];
        end
        if (state_q == ST_BUS && b_ack_i && b_read_o) begin
            rdata_o <= ld_data;
        end
    end

    // replicate narrow store data across all lanes
    always_comb begin
        st_word.word = wdata_i;
        st_strb      = 4'b1111;
        case (mask_i)
            MEM_BYTE, MEM_UBYTE: begin
                st_word.lanes = {4{wdata_i[7:0]}};
                st_strb       = 4'b0001 << addr_i[1:0];
            end
            MEM_HALF, MEM_UHALF: begin
                st_word.halves = {2{wdata_i[15:0]}};
                st_strb        = addr_i[1] ? 4'b1100 : 4'b0011;
            end
            default: ;
        endcase
    end

    // lane pick and extension, as in writeback
    always_comb begin
        ld_word.word = b_data_i;
        case (mask_q)
            MEM_BYTE:  ld_data = {{24{ld_word.lanes[bank_q][7]}}, ld_word.lanes[bank_q]};
            MEM_UBYTE: ld_data = {24'h0, ld_word.lanes[bank_q]};
            MEM_HALF:  ld_data = {{16{ld_word.halves[bank_q[1]][15]}}, ld_word.halves[bank_q[1]]};
            MEM_UHALF: ld_data = {16'h0, ld_word.halves[bank_q[1]]};
            default:   ld_data = ld_word.word;
        endcase
    end

    a_half_align: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req && (mask_i inside {MEM_HALF, MEM_UHALF}) |-> !addr_i[0]);

    a_word_align: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req && (mask_i == MEM_WORD) |-> (addr_i[1:0] == 2'b00));

    // the pipeline must hold off while the bus access runs
    a_no_req_stalled: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        stall_o |-> !req);

endmodule

/* mem_pkg.sv */
package mem_pkg;

    // bus widths
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // bootloader addresses whole words
    localparam int BL_ADDR_W = 14;

    // width and signedness of a load or store, funct3 encoding
    typedef enum logic [2:0] {
        MEM_BYTE  = 3'b000,
        MEM_HALF  = 3'b001,
        MEM_WORD  = 3'b010,
        MEM_UBYTE = 3'b100,
        MEM_UHALF = 3'b101
    } mem_mask_t;

    // one data word, seen whole or by lanes
    typedef union packed {
        logic [DATA_W-1:0]  word;
        logic [3:0][7:0]    lanes;
        logic [1:0][15:0]   halves;
    } mem_word_u;

endpackage

/* mem_subsys.sv */
`timescale 1ns/100ps

module mem_subsys #(
    parameter int MEM_WORDS = 16384
) (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic                            mem_read_i,
    input  logic                            mem_write_i,
    input  logic [31:0]                     addr_i,
    input  logic [mem_pkg::DATA_W-1:0]      wdata_i,
    input  mem_pkg::mem_mask_t              mask_i,
    output logic                            stall_o,
    output logic                            done_o,
    output logic [mem_pkg::DATA_W-1:0]      rdata_o,
    input  logic [mem_pkg::STRB_W-1:0]      bl_strobe_i,
    input  logic [mem_pkg::BL_ADDR_W-1:0]   bl_addr_i,
    input  logic [mem_pkg::DATA_W-1:0]      bl_data_i,
    output logic                            bl_ready_o,
    output logic                            bl_hold_o
);
    import mem_pkg::*;

    // lsu bus, master 0
    logic [31:0]        lsu_addr;
    logic [DATA_W-1:0]  lsu_wdata;
    logic [STRB_W-1:0]  lsu_strb;
    logic               lsu_read;
    logic               lsu_write;
    logic               lsu_ack;
    logic [DATA_W-1:0]  lsu_rdata;

    // bootloader bus, master 1
    logic [31:0]        bl_b_addr;
    logic [DATA_W-1:0]  bl_b_data;
    logic [STRB_W-1:0]  bl_b_strb;
    logic               bl_b_write;
    logic               bl_b_ack;

    // ram side
    logic [31:0]        ram_addr;
    logic [DATA_W-1:0]  ram_wdata;
    logic [STRB_W-1:0]  ram_strb;
    logic               ram_read;
    logic               ram_write;
    logic               ram_ack;
    logic [DATA_W-1:0]  ram_rdata;

    lsu i_lsu (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .mem_read_i     (mem_read_i),
        .mem_write_i    (mem_write_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .mask_i         (mask_i),
        .stall_o        (stall_o),
        .done_o         (done_o),
        .rdata_o        (rdata_o),
        .b_addr_o       (lsu_addr),
        .b_data_o       (lsu_wdata),
        .b_strb_o       (lsu_strb),
        .b_read_o       (lsu_read),
        .b_write_o      (lsu_write),
        .b_ack_i        (lsu_ack),
        .b_data_i       (lsu_rdata)
    );

    boot_loader i_boot_loader (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .bl_strobe_i    (bl_strobe_i),
        .bl_addr_i      (bl_addr_i),
        .bl_data_i      (bl_data_i),
        .bl_ready_o     (bl_ready_o),
        .bl_hold_o      (bl_hold_o),
        .b_addr_o       (bl_b_addr),
        .b_data_o       (bl_b_data),
        .b_strb_o       (bl_b_strb),
        .b_write_o      (bl_b_write),
        .b_ack_i        (bl_b_ack)
    );

    // bootloader only writes, its read side stays idle
    bus_arbiter i_bus_arbiter (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .m0_addr_i      (lsu_addr),
        .m0_data_i      (lsu_wdata),
        .m0_strb_i      (lsu_strb),
        .m0_read_i      (lsu_read),
        .m0_write_i     (lsu_write),
        .m0_ack_o       (lsu_ack),
        .m0_data_o      (lsu_rdata),
        .m1_addr_i      (bl_b_addr),
        .m1_data_i      (bl_b_data),
        .m1_strb_i      (bl_b_strb),
        .m1_read_i      (1'b0),
        .m1_write_i     (bl_b_write),
        .m1_ack_o       (bl_b_ack),
        .m1_data_o      (),
        .s_addr_o       (ram_addr),
        .s_data_o       (ram_wdata),
        .s_strb_o       (ram_strb),
        .s_read_o       (ram_read),
        .s_write_o      (ram_write),
        .s_ack_i        (ram_ack),
        .s_data_i       (ram_rdata)
    );

    data_ram #(
        .MEM_WORDS      (MEM_WORDS)
    ) i_data_ram (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .addr_i         (ram_addr),
        .data_i         (ram_wdata),
        .strb_i         (ram_strb),
        .read_i         (ram_read),
        .write_i        (ram_write),
        .ack_o          (ram_ack),
        .data_o         (ram_rdata)
    );

endmodule

/* tb_mem_subsys.sv */
`timescale 1ns/100ps

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int MEM_WORDS = 16384;
    localparam int REGION    = 64;
    localparam int MAX_ROWS  = 160;
    localparam int WAIT_MAX  = 40;

    localparam logic [2:0] K_FLAG  = 3'd0;
    localparam logic [2:0] K_BLW   = 3'd1;
    localparam logic [2:0] K_ST    = 3'd2;
    localparam logic [2:0] K_LD    = 3'd3;
    localparam logic [2:0] K_ISSUE = 3'd4;
    localparam logic [2:0] K_WAIT  = 3'd5;
    localparam logic [2:0] K_DRAIN = 3'd6;

    // sel holds the mask, the strobe or the flag index
    typedef struct packed {
        logic [2:0]     kind;
        logic [31:0]    addr;
        logic [31:0]    data;
        logic [3:0]     sel;
        logic [31:0]    exp;
    } row_t;

    logic                   clk_i;
    logic                   arst_n_i;
    logic                   mem_read_i;
    logic                   mem_write_i;
    logic [31:0]            addr_i;
    logic [DATA_W-1:0]      wdata_i;
    mem_mask_t              mask_i;
    logic                   stall_o;
    logic                   done_o;
    logic [DATA_W-1:0]      rdata_o;
    logic [STRB_W-1:0]      bl_strobe_i;
    logic [BL_ADDR_W-1:0]   bl_addr_i;
    logic [DATA_W-1:0]      bl_data_i;
    logic                   bl_ready_o;
    logic                   bl_hold_o;

    row_t       rows [MAX_ROWS];
    logic [7:0] shadow [REGION];
    logic [31:0] rnd_q;
    int         n_rows;
    int         checks;
    int         errors;
    int         timeouts;
    int         exp_done;
    int         done_cnt = 0;
    mem_word_u  done_data;
    logic       table_ready;

    mem_subsys #(
        .MEM_WORDS      (MEM_WORDS)
    ) i_mem_subsys (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .mem_read_i     (mem_read_i),
        .mem_write_i    (mem_write_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .mask_i         (mask_i),
        .stall_o        (stall_o),
        .done_o         (done_o),
        .rdata_o        (rdata_o),
        .bl_strobe_i    (bl_strobe_i),
        .bl_addr_i      (bl_addr_i),
        .bl_data_i      (bl_data_i),
        .bl_ready_o     (bl_ready_o),
        .bl_hold_o      (bl_hold_o)
    );

    initial begin
        clk_i = 1'b0;
    end

    always #2 clk_i = ~clk_i;

    // done pulses and their load data sampled mid-cycle
    always @(negedge clk_i) begin
        if (done_o) begin
            done_cnt       <= done_cnt + 1;
            done_data.word <= rdata_o;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected load value straight from the byte model
    function automatic logic [31:0] load_model(input logic [5:0] a, input mem_mask_t mask);
        case (mask)
            MEM_BYTE:  return {{24{shadow[a][7]}}, shadow[a]};
            MEM_UBYTE: return {24'h0, shadow[a]};
            MEM_HALF:  return {{16{shadow[a+6'd1][7]}}, shadow[a+6'd1], shadow[a]};
            MEM_UHALF: return {16'h0, shadow[a+6'd1], shadow[a]};
            default:   return {shadow[a+6'd3], shadow[a+6'd2], shadow[a+6'd1], shadow[a]};
        endcase
    endfunction

    task automatic add_row(input logic [2:0] kind, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] sel,
                           input logic [31:0] exp);
        rows[n_rows].kind = kind;
        rows[n_rows].addr = addr;
        rows[n_rows].data = data;
        rows[n_rows].sel  = sel;
        rows[n_rows].exp  = exp;
        n_rows++;
    endtask

    task automatic bl_write_row(input logic [3:0] word, input logic [31:0] data,
                                input logic [3:0] strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                shadow[{word, 2'(b)}] = data[8*b +: 8];
            end
        end
        add_row(K_BLW, {28'h0, word}, data, strb, 32'h0);
    endtask

    task automatic store_row(input logic [5:0] a, input logic [31:0] data,
                             input mem_mask_t mask);
        int nbytes;
        nbytes = (mask[1:0] == 2'b00) ? 1 : (mask[1:0] == 2'b01) ? 2 : 4;
        for (int b = 0; b < nbytes; b++) begin
            shadow[a + 6'(b)] = data[8*b +: 8];
        end
        add_row(K_ST, {26'h0, a}, data, {1'b0, mask}, 32'h0);
    endtask

    task automatic load_row(input logic [2:0] kind, input logic [5:0] a,
                            input mem_mask_t mask);
        add_row(kind, {26'h0, a}, 32'h0, {1'b0, mask}, load_model(a, mask));
    endtask

    task automatic build_table();
        add_row(K_FLAG, 32'h0, 32'h0, 4'd0, 32'h0);
        add_row(K_FLAG, 32'h0, 32'h0, 4'd1, 32'h0);
        add_row(K_FLAG, 32'h0, 32'h1, 4'd2, 32'h0);
        add_row(K_FLAG, 32'h0, 32'h0, 4'd3, 32'h0);
        // random fill of the test region and a read back
        for (int w = 0; w < 16; w++) begin
            rnd_q = xorshift(rnd_q);
            bl_write_row(4'(w), rnd_q, 4'hf);
        end
        add_row(K_DRAIN, 32'h0, 32'h0, 4'd0, 32'h0);
        for (int w = 0; w < 16; w++) begin
            load_row(K_LD, 6'(4*w), MEM_WORD);
        end
        bl_write_row(4'd3, 32'ha1b2_c3d4, 4'b0101);
        bl_write_row(4'd5, 32'h5566_7788, 4'b1000);
        add_row(K_DRAIN, 32'h0, 32'h0, 4'd0, 32'h0);
        load_row(K_LD, 6'd12, MEM_WORD);
        load_row(K_LD, 6'd20, MEM_WORD);
        // narrow stores from the core
        store_row(6'd25, 32'h0000_00e3, MEM_BYTE);
        store_row(6'd27, 32'h0000_0019, MEM_UBYTE);
        store_row(6'd30, 32'h0000_c0de, MEM_UHALF);
        store_row(6'd32, 32'h0000_7ab4, MEM_HALF);
        load_row(K_LD, 6'd24, MEM_WORD);
        load_row(K_LD, 6'd28, MEM_WORD);
        load_row(K_LD, 6'd32, MEM_WORD);
        // lanes with both sign bits for the extension sweep
        bl_write_row(4'd8, 32'h8a7f_f501, 4'hf);
        bl_write_row(4'd9, 32'h7c31_6e92, 4'hf);
        add_row(K_DRAIN, 32'h0, 32'h0, 4'd0, 32'h0);
        for (int w = 8; w < 10; w++) begin
            for (int b = 0; b < 4; b++) begin
                load_row(K_LD, 6'(4*w + b), MEM_BYTE);
                load_row(K_LD, 6'(4*w + b), MEM_UBYTE);
            end
            for (int b = 0; b < 4; b += 2) begin
                load_row(K_LD, 6'(4*w + b), MEM_HALF);
                load_row(K_LD, 6'(4*w + b), MEM_UHALF);
            end
            load_row(K_LD, 6'(4*w), MEM_WORD);
        end
        // core traffic behind pending bootloader writes
        rnd_q = xorshift(rnd_q);
        bl_write_row(4'd10, rnd_q, 4'hf);
        rnd_q = xorshift(rnd_q);
        bl_write_row(4'd11, rnd_q, 4'hf);
        load_row(K_LD, 6'd8, MEM_WORD);
        store_row(6'd49, 32'h0000_005a, MEM_BYTE);
        add_row(K_DRAIN, 32'h0, 32'h0, 4'd0, 32'h0);
        load_row(K_LD, 6'd40, MEM_WORD);
        load_row(K_LD, 6'd44, MEM_WORD);
        load_row(K_LD, 6'd48, MEM_WORD);
        // core owns the bus while the FIFO fills up
        load_row(K_ISSUE, 6'd18, MEM_HALF);
        add_row(K_FLAG, 32'h0, 32'h1, 4'd0, 32'h0);
        bl_write_row(4'd13, 32'h1357_9bdf, 4'hf);
        bl_write_row(4'd14, 32'h2468_ace0, 4'hf);
        add_row(K_FLAG, 32'h0, 32'h0, 4'd2, 32'h0);
        add_row(K_FLAG, 32'h0, 32'h1, 4'd3, 32'h0);
        load_row(K_WAIT, 6'd18, MEM_HALF);
        bl_write_row(4'd15, 32'hfeed_0042, 4'b0011);
        add_row(K_DRAIN, 32'h0, 32'h0, 4'd0, 32'h0);
        for (int w = 0; w < 16; w++) begin
            load_row(K_LD, 6'(4*w), MEM_WORD);
        end
    endtask

    task automatic check_word(input string name, input mem_word_u got, input mem_word_u exp);
        checks++;
        if (got.word !== exp.word) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h, expected %h",
                     $time, name, got.word, exp.word);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    task automatic issue_core(input row_t r);
        int n;
        n = 0;
        while (stall_o && n < WAIT_MAX) begin
            step();
            n++;
        end
        if (stall_o) begin
            report_timeout("stall_o stayed high, core request not issued");
        end else begin
            mem_read_i  = (r.kind != K_ST);
            mem_write_i = (r.kind == K_ST);
            addr_i      = r.addr;
            wdata_i     = r.data;
            mask_i      = mem_mask_t'(r.sel[2:0]);
            exp_done++;
            step();
            mem_read_i  = 1'b0;
            mem_write_i = 1'b0;
        end
    endtask

    task automatic finish_core(input row_t r, input logic check);
        mem_word_u exp_w;
        int n;
        n = 0;
        exp_w.word = r.exp;
        while (done_cnt < exp_done && n < WAIT_MAX) begin
            step();
            n++;
        end
        if (done_cnt < exp_done) begin
            report_timeout("no done_o pulse after a core request");
            exp_done = done_cnt;
        end else if (check) begin
            check_word("rdata_o", done_data, exp_w);
        end
    endtask

    task automatic apply_row(input row_t r);
        int n;
        n = 0;
        case (r.kind)
            K_FLAG: begin
                case (r.sel)
                    4'd0:    check_flag("stall_o", stall_o, r.data[0]);
                    4'd1:    check_flag("done_o", done_o, r.data[0]);
                    4'd2:    check_flag("bl_ready_o", bl_ready_o, r.data[0]);
                    default: check_flag("bl_hold_o", bl_hold_o, r.data[0]);
                endcase
            end
            K_BLW: begin
                while (!bl_ready_o && n < WAIT_MAX) begin
                    step();
                    n++;
                end
                if (!bl_ready_o) begin
                    report_timeout("bl_ready_o stayed low, bootloader write not offered");
                end else begin
                    bl_strobe_i = r.sel;
                    bl_addr_i   = r.addr[BL_ADDR_W-1:0];
                    bl_data_i   = r.data;
                    step();
                    bl_strobe_i = '0;
                end
            end
            K_DRAIN: begin
                while (bl_hold_o && n < WAIT_MAX) begin
                    step();
                    n++;
                end
                if (bl_hold_o) begin
                    report_timeout("bl_hold_o stayed high, bootloader writes did not drain");
                end
            end
            K_ISSUE: issue_core(r);
            K_WAIT:  finish_core(r, 1'b1);
            K_ST: begin
                issue_core(r);
                finish_core(r, 1'b0);
            end
            default: begin
                issue_core(r);
                finish_core(r, 1'b1);
            end
        endcase
    endtask

    initial begin
        arst_n_i    = 1'b0;
        mem_read_i  = 1'b0;
        mem_write_i = 1'b0;
        addr_i      = '0;
        wdata_i     = '0;
        mask_i      = MEM_WORD;
        bl_strobe_i = '0;
        bl_addr_i   = '0;
        bl_data_i   = '0;
        n_rows      = 0;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        exp_done    = 0;
        rnd_q       = 32'he47d;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            apply_row(rows[i]);
        end
        $display("rows %0d, checks %0d, errors %0d, timeouts %0d",
                 n_rows, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // bound on the whole run scaled by the table length
    initial begin
        wait (table_ready);
        repeat (n_rows * WAIT_MAX) @(posedge clk_i);
        $display("ERROR: watchdog expired after %0d cycles, the run did not finish",
                 n_rows * WAIT_MAX);
        $display("Some tests failed");
        $finish;
    end

endmodule
